//--- list.f
+incdir+common
common/rv_pkg.sv
decoder/instr_decoder.sv
decoder/imm_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
tests/decode_stage_sva.sv
tests/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_decode_stage -o sim_decode_stage

./obj_dir/sim_decode_stage

//--- tests/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_decode_stage import rv_pkg::*; ();

	logic                  clk;
	logic                  arst_n;
	logic                  valid;
	logic [`RV_XLEN-1:0]   instr;
	logic                  wb_we;
	logic [`RV_REG_AW-1:0] wb_rd;
	logic [`RV_XLEN-1:0]   wb_data;

	logic                  out_valid, we, branch, bneq, jal, jalr, illegal;
	logic [`RV_XLEN-1:0]   rs1_data, rs2_data, imm;
	logic [`RV_REG_AW-1:0] rd;
	alu_fn_e               alu_fn;
	b_sel_e                b_sel;
	wb_sel_e               wb_sel;
	mem_op_e               mem_op;
	muldiv_op_e            muldiv_op;

	logic [`RV_XLEN-1:0] shadow [`RV_NREGS];   // predicted register contents
	logic [`RV_XLEN-1:0] q_instr [$];          // in flight, oldest first
	logic [`RV_XLEN-1:0] q_rs1 [$];
	logic [`RV_XLEN-1:0] q_rs2 [$];
	string               q_name [$];
	int                  n_issued, n_checked;

	decode_stage dut0 (
		.clk(clk), .i_arst_n(arst_n), .i_valid(valid), .i_instr(instr),
		.i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
		.o_valid(out_valid), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_imm(imm),
		.o_rd(rd), .o_alu_fn(alu_fn), .o_b_sel(b_sel), .o_wb_sel(wb_sel), .o_we(we),
		.o_mem_op(mem_op), .o_muldiv_op(muldiv_op), .o_branch(branch), .o_bneq(bneq),
		.o_jal(jal), .o_jalr(jalr), .o_illegal(illegal)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_alu(input string name, input alu_fn_e exp, input alu_fn_e act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s alu_fn: expected %s (%h), got %s (%h)",
				name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_mem(input string name, input mem_op_e exp, input mem_op_e act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s mem_op: expected %s (%h), got %s (%h)",
				name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_wb(input string name, input wb_sel_e exp, input wb_sel_e act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s wb_sel: expected %s (%h), got %s (%h)",
				name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_muldiv(input string name, input muldiv_op_e exp,
			input muldiv_op_e act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s muldiv_op: expected %s (%h), got %s (%h)",
				name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_bsel(input string name, input b_sel_e exp, input b_sel_e act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s b_sel: expected %s (%h), got %s (%h)",
				name, exp.name(), exp, act.name(), act));
	endtask

	task automatic check_word(input string name, input string field,
			input logic [`RV_XLEN-1:0] exp, input logic [`RV_XLEN-1:0] act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s %s: expected %h, got %h", name, field, exp, act));
	endtask

	task automatic check_bit(input string name, input string field, input logic exp,
			input logic act);
		if (exp !== act)
			fail_stop($sformatf("[ERROR] %s %s: expected %b, got %b", name, field, exp, act));
	endtask

	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] a2,
			input logic [4:0] a1, input logic [2:0] f3, input logic [4:0] d,
			input logic [6:0] op);
		return {f7, a2, a1, f3, d, op};
	endfunction

	// plain alu ops straight from funct3
	function automatic alu_fn_e alu_of_funct3(input logic [2:0] f3);
		case (f3)
			3'b000:  return ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// expected execute controls for one instruction
	function automatic void ref_decode(input logic [31:0] ins, output alu_fn_e alu,
			output b_sel_e bsel, output wb_sel_e wb, output logic w, output mem_op_e mem,
			output muldiv_op_e md, output logic br, output logic bne, output logic j,
			output logic jr, output logic ill);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = ins[14:12];
		f7 = ins[31:25];
		alu = ALU_ADD;
		bsel = B_REG;
		wb = WB_ALU;
		mem = MEM_NONE;
		md = MD_MUL;
		{w, br, bne, j, jr, ill} = '0;
		case (ins[6:0])
			OPC_OP: begin
				w = 1'b1;
				if (f7 == 7'h00) alu = alu_of_funct3(f3);
				else if (f7 == 7'h20 && f3 == 3'b000) alu = ALU_SUB;
				else if (f7 == 7'h20 && f3 == 3'b101) alu = ALU_SRA;
				else if (f7 == 7'h01) begin
					wb = WB_MULDIV;
					case (f3)
						3'b000:  md = MD_MUL;
						3'b001:  md = MD_MULH;
						3'b010:  md = MD_MULHSU;
						3'b011:  md = MD_MULHU;
						3'b100:  md = MD_DIV;
						3'b101:  md = MD_DIVU;
						3'b110:  md = MD_REM;
						default: md = MD_REMU;
					endcase
				end else ill = 1'b1;
			end
			OPC_OP_IMM: begin
				w = 1'b1;
				bsel = (f3 == 3'b001 || f3 == 3'b101) ? B_SHAMT : B_IMM;
				alu = alu_of_funct3(f3);
				if (f3 == 3'b001 && f7 != 7'h00) ill = 1'b1;
				if (f3 == 3'b101 && f7 == 7'h20) alu = ALU_SRA;
				else if (f3 == 3'b101 && f7 != 7'h00) ill = 1'b1;
			end
			OPC_LOAD: begin
				w = 1'b1;
				bsel = B_IMM;
				wb = WB_LOAD;
				case (f3)
					3'b000:  mem = MEM_LB;
					3'b001:  mem = MEM_LH;
					3'b010:  mem = MEM_LW;
					3'b100:  mem = MEM_LBU;
					3'b101:  mem = MEM_LHU;
					default: ill = 1'b1;
				endcase
			end
			OPC_STORE: begin
				bsel = B_IMM;
				case (f3)
					3'b000:  mem = MEM_SB;
					3'b001:  mem = MEM_SH;
					3'b010:  mem = MEM_SW;
					default: ill = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				br = 1'b1;
				bne = (f3 == 3'b001);
				case (f3)
					3'b000, 3'b001: alu = ALU_SUB;   // compare by subtract
					3'b100:  alu = ALU_SLT;
					3'b101:  alu = ALU_BGE;
					3'b110:  alu = ALU_SLTU;
					3'b111:  alu = ALU_BGEU;
					default: ill = 1'b1;
				endcase
			end
			OPC_JAL: begin
				{j, w} = 2'b11;
				wb = WB_PC4;
			end
			OPC_JALR: begin
				{jr, w} = 2'b11;
				bsel = B_IMM;
				wb = WB_PC4;
				ill = (f3 != 3'b000);
			end
			OPC_LUI: begin
				w = 1'b1;
				wb = WB_IMM;
			end
			OPC_AUIPC: begin
				w = 1'b1;
				wb = WB_AUIPC;
			end
			default: ill = 1'b1;
		endcase
		if (ill) begin   // no side effects at all
			{w, br, bne, j, jr} = '0;
			mem = MEM_NONE;
		end
	endfunction

	// immediate format follows the opcode, see the isa manual
	function automatic logic [31:0] ref_imm(input logic [31:0] ins);
		case (ins[6:0])
			OPC_STORE:  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
			OPC_BRANCH: return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			OPC_JAL:    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			OPC_LUI, OPC_AUIPC: return {ins[31:12], 12'b0};
			default:    return {{20{ins[31]}}, ins[31:20]};
		endcase
	endfunction

	// operand seen in decode, same-cycle write-back wins
	function automatic logic [31:0] operand(input logic [4:0] a, input logic w,
			input logic [4:0] d, input logic [31:0] data);
		if (a == 5'd0)
			return '0;
		else if (w && d == a)
			return data;
		else
			return shadow[a];
	endfunction

	task automatic issue(input string name, input logic [31:0] ins, input logic w,
			input logic [4:0] d, input logic [31:0] data);
		@(negedge clk);
		valid = 1'b1;
		instr = ins;
		wb_we = w;
		wb_rd = d;
		wb_data = data;
		q_instr.push_back(ins);
		q_name.push_back(name);
		q_rs1.push_back(operand(ins[19:15], w, d, data));
		q_rs2.push_back(operand(ins[24:20], w, d, data));
		if (w && d != 5'd0) shadow[d] = data;   // lands at the next rising edge
		n_issued++;
	endtask

	task automatic write_reg(input logic [4:0] d, input logic [31:0] data);
		@(negedge clk);
		valid = 1'b0;
		wb_we = 1'b1;
		wb_rd = d;
		wb_data = data;
		if (d != 5'd0) shadow[d] = data;
	endtask

	// quiet inputs, then wait until every strobe came out
	task automatic idle();
		int t;
		@(negedge clk);
		valid = 1'b0;
		wb_we = 1'b0;
		t = 0;
		while (q_instr.size() != 0 && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (q_instr.size() != 0)
			fail_stop("timeout: o_valid did not come for an issued instruction");
	endtask

	initial begin : check_proc
		logic [31:0] ins, e_rs1, e_rs2;
		string       nm;
		alu_fn_e     e_alu;
		b_sel_e      e_bsel;
		wb_sel_e     e_wb;
		mem_op_e     e_mem;
		muldiv_op_e  e_md;
		logic        e_we, e_br, e_bne, e_jal, e_jalr, e_ill;
		forever begin
			@(negedge clk);   // outputs settled since the rising edge
			if (out_valid) begin
				if (q_instr.size() == 0) begin
					fail_stop("o_valid high with no instruction in flight");
				end else begin
					ins = q_instr.pop_front();
					nm = q_name.pop_front();
					e_rs1 = q_rs1.pop_front();
					e_rs2 = q_rs2.pop_front();
					ref_decode(ins, e_alu, e_bsel, e_wb, e_we, e_mem, e_md, e_br, e_bne,
						e_jal, e_jalr, e_ill);
					check_bit(nm, "illegal", e_ill, illegal);
					check_bit(nm, "we", e_we, we);
					check_mem(nm, e_mem, mem_op);
					check_bit(nm, "branch", e_br, branch);
					check_bit(nm, "bneq", e_bne, bneq);
					check_bit(nm, "jal", e_jal, jal);
					check_bit(nm, "jalr", e_jalr, jalr);
					check_word(nm, "imm", ref_imm(ins), imm);
					check_word(nm, "rs1_data", e_rs1, rs1_data);
					check_word(nm, "rs2_data", e_rs2, rs2_data);
					check_word(nm, "rd", 32'(ins[11:7]), 32'(rd));
					if (!e_ill) begin   // rest is don't-care when illegal
						check_alu(nm, e_alu, alu_fn);
						check_bsel(nm, e_bsel, b_sel);
						check_wb(nm, e_wb, wb_sel);
						if (e_wb == WB_MULDIV)
							check_muldiv(nm, e_md, muldiv_op);
					end
					n_checked++;
				end
			end
		end
	end

	initial begin : stimulus
		logic [31:0] ins;
		logic [4:0]  r;
		int          k;
		void'($urandom(29346));
		arst_n = 1'b0;
		valid = 1'b0;
		instr = '0;
		wb_we = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		n_issued = 0;
		n_checked = 0;
		for (k = 0; k < `RV_NREGS; k++)
			shadow[k] = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// state right after reset
		check_bit("reset", "valid", 1'b0, out_valid);
		check_bit("reset", "we", 1'b0, we);
		check_bit("reset", "branch", 1'b0, branch);
		check_bit("reset", "bneq", 1'b0, bneq);
		check_bit("reset", "jal", 1'b0, jal);
		check_bit("reset", "jalr", 1'b0, jalr);
		check_bit("reset", "illegal", 1'b0, illegal);
		check_mem("reset", MEM_NONE, mem_op);
		for (k = 0; k < `RV_NREGS; k++)   // every register still zero
			issue("reset_regs", encode(7'h00, 5'(31 - k), 5'(k), 3'b000, 5'(k), OPC_OP),
				1'b0, 5'd0, 32'd0);
		idle();

		repeat (30) begin   // reg-reg, bit 30 only on add and srl
			ins = $urandom;
			ins[31:25] = ((ins[14:12] == 3'b000 || ins[14:12] == 3'b101) && ins[30]) ?
				7'h20 : 7'h00;
			ins[6:0] = OPC_OP;
			issue("alu_reg", ins, 1'b0, 5'd0, 32'd0);
		end
		repeat (30) begin   // reg-imm, shifts get a legal funct7
			ins = $urandom;
			ins[6:0] = OPC_OP_IMM;
			if (ins[13:12] == 2'b01)
				ins[31:25] = {1'b0, ins[14] & ins[30], 5'b0};
			issue("alu_imm", ins, 1'b0, 5'd0, 32'd0);
		end
		idle();

		repeat (24) begin
			ins = $urandom;
			ins[31:25] = 7'h01;   // M extension
			ins[6:0] = OPC_OP;
			issue("muldiv", ins, 1'b0, 5'd0, 32'd0);
		end
		idle();

		for (k = 0; k < 6; k++) begin   // lb lh lw lbu lhu, 3 is reserved
			if (k != 3) begin
				repeat (4) begin
					ins = $urandom;
					ins[14:12] = 3'(k);
					ins[6:0] = OPC_LOAD;
					issue("load", ins, 1'b0, 5'd0, 32'd0);
				end
			end
		end
		for (k = 0; k < 3; k++) begin
			repeat (4) begin
				ins = $urandom;
				ins[14:12] = 3'(k);
				ins[6:0] = OPC_STORE;
				issue("store", ins, 1'b0, 5'd0, 32'd0);
			end
		end
		idle();

		for (k = 0; k < 8; k++) begin
			if (k != 2 && k != 3) begin
				repeat (3) begin
					ins = $urandom;
					ins[14:12] = 3'(k);
					ins[6:0] = OPC_BRANCH;
					issue("branch", ins, 1'b0, 5'd0, 32'd0);
				end
			end
		end
		repeat (6) begin
			ins = $urandom;
			issue("jal", {ins[31:7], OPC_JAL}, 1'b0, 5'd0, 32'd0);
			issue("jalr", {ins[31:15], 3'b000, ins[11:7], OPC_JALR}, 1'b0, 5'd0, 32'd0);
			issue("lui", {ins[31:7], OPC_LUI}, 1'b0, 5'd0, 32'd0);
			issue("auipc", {ins[31:7], OPC_AUIPC}, 1'b0, 5'd0, 32'd0);
		end
		idle();

		repeat (40) begin   // one illegal form per pass
			ins = $urandom;
			case ($urandom % 7)
				0: ins[1:0] = 2'($urandom % 3);   // not a 32-bit opcode
				1: ins[6:0] = ins[0] ? 7'b0001111 : 7'b1110011;   // fence, system
				2: ins = {ins[31:27], 2'b10, ins[24:7], 7'(OPC_OP)};
				3: ins = {ins[31:15], 3'($urandom % 7 + 1), ins[11:7], 7'(OPC_JALR)};
				4: ins = {ins[31:15], ins[14], 2'b11, ins[11:7], 7'(OPC_LOAD)};   // 011, 111
				5: ins = {ins[31:15], 3'($urandom % 5 + 3), ins[11:7], 7'(OPC_STORE)};
				default: ins = {ins[31:15], 2'b01, ins[12], ins[11:7], 7'(OPC_BRANCH)};
			endcase
			issue("illegal", ins, 1'b0, 5'd0, 32'd0);
		end
		idle();

		// register file through the write-back port
		repeat (40) write_reg(5'($urandom), $urandom);
		repeat (30) begin
			ins = encode(7'h00, 5'($urandom), 5'($urandom), 3'b000, 5'($urandom), OPC_OP);
			issue("rf_read", ins, 1'b0, 5'd0, 32'd0);
		end
		idle();
		repeat (20) begin   // write lands in the same cycle as the read
			r = 5'($urandom % 31 + 1);
			ins = encode(7'h00, 5'($urandom), r, 3'b000, 5'd1, OPC_OP);
			issue("rf_bypass", ins, 1'b1, r, $urandom);
		end
		idle();
		repeat (5) begin
			write_reg(5'd0, $urandom);
			issue("rf_x0", encode(7'h00, 5'd0, 5'd0, 3'b110, 5'd3, OPC_OP),
				1'b1, 5'd0, $urandom);
		end
		idle();

		if (n_checked == n_issued) begin
			$display("Everything OK");
			$finish;
		end else begin
			fail_stop($sformatf("%0d instructions issued, %0d checked", n_issued, n_checked));
		end
	end

endmodule

`default_nettype wire

//--- tests/decode_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva import rv_pkg::*; (
	input logic    clk,
	input logic    i_arst_n,
	input logic    i_valid,
	input logic    o_valid,
	input logic    o_we,
	input mem_op_e o_mem_op,
	input logic    o_branch,
	input logic    o_jal,
	input logic    o_jalr,
	input logic    o_illegal
);

	a_reset_valid: assert property (@(posedge clk) !i_arst_n |-> !o_valid)
		else $error("o_valid high while reset is active");

	// valid is a plain one-stage delay of the strobe
	a_valid_set: assert property (@(posedge clk) disable iff (!i_arst_n) i_valid |=> o_valid)
		else $error("strobe not followed by o_valid");
	a_valid_clr: assert property (@(posedge clk) disable iff (!i_arst_n) !i_valid |=> !o_valid)
		else $error("o_valid without a strobe one cycle before");

	a_illegal_quiet: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_illegal |-> (!o_we && o_mem_op == MEM_NONE))
		else $error("illegal instruction with write or memory effect");

	a_one_flow: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0({o_branch, o_jal, o_jalr}))
		else $error("more than one of branch, jal, jalr");

endmodule

bind decode_stage decode_stage_sva sva0 (
	.clk(clk), .i_arst_n(i_arst_n), .i_valid(i_valid), .o_valid(o_valid), .o_we(o_we),
	.o_mem_op(o_mem_op), .o_branch(o_branch), .o_jal(o_jal), .o_jalr(o_jalr),
	.o_illegal(o_illegal)
);

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module decode_stage import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_valid,      // one-cycle strobe with i_instr
	input  logic [`RV_XLEN-1:0]   i_instr,
	input  logic                  i_wb_we,
	input  logic [`RV_REG_AW-1:0] i_wb_rd,
	input  logic [`RV_XLEN-1:0]   i_wb_data,
	output logic                  o_valid,
	output logic [`RV_XLEN-1:0]   o_rs1_data,
	output logic [`RV_XLEN-1:0]   o_rs2_data,
	output logic [`RV_XLEN-1:0]   o_imm,
	output logic [`RV_REG_AW-1:0] o_rd,
	output alu_fn_e               o_alu_fn,
	output b_sel_e                o_b_sel,
	output wb_sel_e               o_wb_sel,
	output logic                  o_we,
	output mem_op_e               o_mem_op,
	output muldiv_op_e            o_muldiv_op,
	output logic                  o_branch,
	output logic                  o_bneq,
	output logic                  o_jal,
	output logic                  o_jalr,
	output logic                  o_illegal
);

	// instruction fields
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [`RV_REG_AW-1:0] rs1, rs2, rd;

	// decoder results, captured into ID/EX below
	alu_fn_e             dec_alu_fn;
	b_sel_e              dec_b_sel;
	wb_sel_e             dec_wb_sel;
	mem_op_e             dec_mem_op;
	muldiv_op_e          dec_muldiv_op;
	imm_fmt_e            dec_imm_fmt;
	logic                dec_we, dec_branch, dec_bneq, dec_jal, dec_jalr, dec_illegal;
	logic [`RV_XLEN-1:0] imm, rs1_data, rs2_data;

	assign opcode = i_instr[6:0];
	assign rd     = i_instr[11:7];
	assign funct3 = i_instr[14:12];
	assign rs1    = i_instr[19:15];
	assign rs2    = i_instr[24:20];
	assign funct7 = i_instr[31:25];

	instr_decoder u_dec (
		.i_opcode(opcode_e'(opcode)), .i_funct3(funct3), .i_funct7(funct7),
		.o_alu_fn(dec_alu_fn), .o_b_sel(dec_b_sel), .o_wb_sel(dec_wb_sel),
		.o_we(dec_we), .o_mem_op(dec_mem_op), .o_muldiv_op(dec_muldiv_op),
		.o_branch(dec_branch), .o_bneq(dec_bneq), .o_jal(dec_jal),
		.o_jalr(dec_jalr), .o_illegal(dec_illegal), .o_imm_fmt(dec_imm_fmt)
	);

	imm_gen u_imm (.i_instr(i_instr), .i_fmt(dec_imm_fmt), .o_imm(imm));

	reg_file u_rf (
		.clk(clk), .i_arst_n(i_arst_n), .i_rs1(rs1), .i_rs2(rs2),
		.i_we(i_wb_we), .i_rd(i_wb_rd), .i_wdata(i_wb_data),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	// ID/EX control part, reset to a harmless nop
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid   <= 1'b0;
			o_we      <= 1'b0;
			o_mem_op  <= MEM_NONE;
			o_branch  <= 1'b0;
			o_bneq    <= 1'b0;
			o_jal     <= 1'b0;
			o_jalr    <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			o_valid <= i_valid;     // reloaded every cycle
			if (i_valid) begin      // otherwise hold last instruction
				o_we      <= dec_we;
				o_mem_op  <= dec_mem_op;
				o_branch  <= dec_branch;
				o_bneq    <= dec_bneq;
				o_jal     <= dec_jal;
				o_jalr    <= dec_jalr;
				o_illegal <= dec_illegal;
			end
		end
	end

	// ID/EX payload part
	always_ff @(posedge clk) begin
		if (i_valid) begin
			o_rs1_data  <= rs1_data;    // includes same-cycle write-back
			o_rs2_data  <= rs2_data;
			o_imm       <= imm;
			o_rd        <= rd;
			o_alu_fn    <= dec_alu_fn;
			o_b_sel     <= dec_b_sel;
			o_wb_sel    <= dec_wb_sel;
			o_muldiv_op <= dec_muldiv_op;
		end
	end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic [`RV_REG_AW-1:0] i_rs1,
	input  logic [`RV_REG_AW-1:0] i_rs2,
	input  logic                  i_we,
	input  logic [`RV_REG_AW-1:0] i_rd,
	input  logic [`RV_XLEN-1:0]   i_wdata,
	output logic [`RV_XLEN-1:0]   o_rs1_data,
	output logic [`RV_XLEN-1:0]   o_rs2_data
);

	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];   // no storage for x0
	logic                wr_en;

	assign wr_en = i_we && (i_rd != '0);        // x0 writes dropped

	// one read port with bypass from write-back
	function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && (addr == i_rd))
			return i_wdata;   // forward, write-back overlaps decode
		else
			return regs[addr];
	endfunction

	always_comb begin
		o_rs1_data = read_port(i_rs1);
		o_rs2_data = read_port(i_rs2);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < `RV_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[i_rd] <= i_wdata;
		end
	end

endmodule

`default_nettype wire

//--- decoder/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module imm_gen import rv_pkg::*; (
	input  logic [`RV_XLEN-1:0] i_instr,
	input  imm_fmt_e            i_fmt,
	output logic [`RV_XLEN-1:0] o_imm
);

	logic sign;

	assign sign = i_instr[31];  // every format takes its sign from bit 31

	always_comb begin
		case (i_fmt)
			IMM_I: o_imm = {{20{sign}}, i_instr[31:20]};
			IMM_S: o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			IMM_B: begin
				// offset in halfwords, lsb forced to zero
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
					i_instr[11:8], 1'b0};
			end
			IMM_U: o_imm = {i_instr[31:12], 12'b0};   // upper 20 bits
			IMM_J: begin
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
					i_instr[30:21], 1'b0};
			end
			default: o_imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- decoder/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_pkg::*; (
	input  opcode_e    i_opcode,
	input  logic [2:0] i_funct3,
	input  logic [6:0] i_funct7,    // bit 5 is instr[30]
	output alu_fn_e    o_alu_fn,
	output b_sel_e     o_b_sel,
	output wb_sel_e    o_wb_sel,
	output logic       o_we,
	output mem_op_e    o_mem_op,
	output muldiv_op_e o_muldiv_op,
	output logic       o_branch,
	output logic       o_bneq,      // bne, alu still does sub
	output logic       o_jal,
	output logic       o_jalr,
	output logic       o_illegal,
	output imm_fmt_e   o_imm_fmt
);

	always_comb begin
		// defaults describe a nop
		o_alu_fn    = ALU_ADD;
		o_b_sel     = B_REG;
		o_wb_sel    = WB_ALU;
		o_we        = 1'b0;
		o_mem_op    = MEM_NONE;
		o_muldiv_op = MD_MUL;
		o_branch    = 1'b0;
		o_bneq      = 1'b0;
		o_jal       = 1'b0;
		o_jalr      = 1'b0;
		o_illegal   = 1'b0;
		o_imm_fmt   = IMM_I;

		case (i_opcode)
			OPC_OP: begin
				o_we = 1'b1;
				case (i_funct7)
					7'b0000000: o_alu_fn = alu_fn_e'({1'b0, i_funct3});
					7'b0100000: begin   // only sub and sra use bit 30
						if (i_funct3 == 3'b000)      o_alu_fn = ALU_SUB;
						else if (i_funct3 == 3'b101) o_alu_fn = ALU_SRA;
						else                         o_illegal = 1'b1;
					end
					7'b0000001: begin   // M extension
						o_wb_sel = WB_MULDIV;
						case (i_funct3)
							3'b000:  o_muldiv_op = MD_MUL;
							3'b001:  o_muldiv_op = MD_MULH;
							3'b010:  o_muldiv_op = MD_MULHSU;
							3'b011:  o_muldiv_op = MD_MULHU;
							3'b100:  o_muldiv_op = MD_DIV;
							3'b101:  o_muldiv_op = MD_DIVU;
							3'b110:  o_muldiv_op = MD_REM;
							default: o_muldiv_op = MD_REMU;
						endcase
					end
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				o_we    = 1'b1;
				o_b_sel = B_IMM;
				case (i_funct3)
					3'b001: begin   // slli
						o_b_sel   = B_SHAMT;
						o_alu_fn  = ALU_SLL;
						o_illegal = (i_funct7 != 7'b0000000);
					end
					3'b101: begin   // srli / srai picked by bit 30
						o_b_sel = B_SHAMT;
						if (i_funct7 == 7'b0000000)      o_alu_fn = ALU_SRL;
						else if (i_funct7 == 7'b0100000) o_alu_fn = ALU_SRA;
						else                             o_illegal = 1'b1;
					end
					default: o_alu_fn = alu_fn_e'({1'b0, i_funct3});
				endcase
			end
			OPC_LOAD: begin
				o_we     = 1'b1;
				o_b_sel  = B_IMM;   // address = rs1 + imm
				o_wb_sel = WB_LOAD;
				case (i_funct3)
					3'b000:  o_mem_op = MEM_LB;
					3'b001:  o_mem_op = MEM_LH;
					3'b010:  o_mem_op = MEM_LW;
					3'b100:  o_mem_op = MEM_LBU;
					3'b101:  o_mem_op = MEM_LHU;
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				o_b_sel   = B_IMM;
				o_imm_fmt = IMM_S;
				case (i_funct3)
					3'b000:  o_mem_op = MEM_SB;
					3'b001:  o_mem_op = MEM_SH;
					3'b010:  o_mem_op = MEM_SW;
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				o_branch  = 1'b1;
				o_imm_fmt = IMM_B;
				case (i_funct3)
					3'b000:  o_alu_fn = ALU_SUB;    // beq
					3'b001: begin                   // bne
						o_alu_fn = ALU_SUB;
						o_bneq   = 1'b1;
					end
					3'b100:  o_alu_fn = ALU_SLT;    // blt
					3'b101:  o_alu_fn = ALU_BGE;
					3'b110:  o_alu_fn = ALU_SLTU;   // bltu
					3'b111:  o_alu_fn = ALU_BGEU;
					default: o_illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				o_jal     = 1'b1;
				o_we      = 1'b1;
				o_wb_sel  = WB_PC4;
				o_imm_fmt = IMM_J;
			end
			OPC_JALR: begin
				o_jalr    = 1'b1;
				o_we      = 1'b1;
				o_b_sel   = B_IMM;  // target = rs1 + imm
				o_wb_sel  = WB_PC4;
				o_illegal = (i_funct3 != 3'b000);
			end
			OPC_LUI: begin
				o_we      = 1'b1;
				o_wb_sel  = WB_IMM;
				o_imm_fmt = IMM_U;
			end
			OPC_AUIPC: begin
				o_we      = 1'b1;
				o_wb_sel  = WB_AUIPC;
				o_imm_fmt = IMM_U;
			end
			default: o_illegal = 1'b1;  // fence, system, unknown
		endcase

		// illegal instructions must leave no side effect
		if (o_illegal) begin
			o_we     = 1'b0;
			o_mem_op = MEM_NONE;
			o_branch = 1'b0;
			o_bneq   = 1'b0;
			o_jal    = 1'b0;
			o_jalr   = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// major opcodes of RV32IM, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// alu function is {instr[30], funct3} for reg-reg ops
	// blt and bltu reuse slt and sltu, beq and bne reuse sub
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,   // also beq / bne
		ALU_BGE  = 4'b1001,
		ALU_BGEU = 4'b1010,
		ALU_SRA  = 4'b1101
	} alu_fn_e;

	// bit 3 store, bits 2:1 size (11 word, 01 half, 10 byte), bit 0 signed
	typedef enum logic [3:0] {
		MEM_NONE = 4'b0000,
		MEM_SW   = 4'b1111,
		MEM_SH   = 4'b1011,
		MEM_SB   = 4'b1101,
		MEM_LW   = 4'b0111,
		MEM_LH   = 4'b0011,
		MEM_LHU  = 4'b0010,
		MEM_LB   = 4'b0101,
		MEM_LBU  = 4'b0100
	} mem_op_e;

	// note div/divu and rem/remu are swapped against funct3
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIVU   = 3'b100,
		MD_DIV    = 3'b101,
		MD_REMU   = 3'b110,
		MD_REM    = 3'b111
	} muldiv_op_e;

	typedef enum logic [2:0] {
		WB_ALU    = 3'b000,
		WB_PC4    = 3'b001,   // link address for jal / jalr
		WB_MULDIV = 3'b010,
		WB_IMM    = 3'b011,   // lui
		WB_AUIPC  = 3'b100,   // pc + u-immediate
		WB_LOAD   = 3'b111
	} wb_sel_e;

	typedef enum logic [1:0] {
		B_REG   = 2'b00,
		B_IMM   = 2'b01,
		B_SHAMT = 2'b10     // shift amount from imm[4:0]
	} b_sel_e;

	typedef enum logic [2:0] {
		IMM_I = 3'd0,
		IMM_S = 3'd1,
		IMM_B = 3'd2,
		IMM_U = 3'd3,
		IMM_J = 3'd4
	} imm_fmt_e;

endpackage

`default_nettype wire

//--- common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// fixed by the RV32 ISA
`define RV_XLEN 32      // data and instruction width
`define RV_NREGS 32     // integer register count incl. x0
`define RV_REG_AW 5     // log2 of RV_NREGS

`endif
